// File: common/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width on the requester port and the bus
`define MEM_ADDR_W 32

// one memory word, also the bus data width
`define MEM_DATA_W 64

// number of 64-bit words in the sram
`define MEM_DEPTH_WORDS 512

// first byte address of the sram window
`define MEM_BASE 32'h8000_0000

// axi response codes
// decerr is never generated, out-of-window goes to slverr
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

// File: common/mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

	// byte address, low bits ignored by the slave
	typedef logic [`MEM_ADDR_W-1:0] addr_t;

	// one data word
	typedef logic [`MEM_DATA_W-1:0] data_t;

	// one enable bit per byte lane
	typedef logic [`MEM_DATA_W/8-1:0] strb_t;

	// axi response code
	typedef logic [1:0] resp_t;

	// w channel beat, 72 bits
	// data in the upper bits
	typedef struct packed {
		data_t data;
		strb_t strb;
	} wbeat_t;

	// r channel beat, 66 bits
	typedef struct packed {
		data_t data;
		resp_t resp;
	} rbeat_t;

endpackage

`default_nettype wire

// File: common/axi_lite_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_lite_if;
	import mem_pkg::*;

	// read address
	logic arvalid;
	logic arready;
	addr_t araddr;

	// write address
	logic awvalid;
	logic awready;
	addr_t awaddr;

	// write data
	logic wvalid;
	logic wready;
	data_t wdata;
	strb_t wstrb;

	// read data
	logic rvalid;
	logic rready;
	data_t rdata;
	resp_t rresp;

	// write response
	logic bvalid;
	logic bready;
	resp_t bresp;

	// requests and response readies
	modport master (
		output arvalid, araddr, awvalid, awaddr, wvalid, wdata, wstrb, rready, bready,
		input arready, awready, wready, rvalid, rdata, rresp, bvalid, bresp
	);

	// mirror of the master side
	modport slave (
		input arvalid, araddr, awvalid, awaddr, wvalid, wdata, wstrb, rready, bready,
		output arready, awready, wready, rvalid, rdata, rresp, bvalid, bresp
	);

endinterface

`default_nettype wire

// File: source/lsu_axi_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defs.svh"

module lsu_axi_master (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_write,
	input mem_pkg::addr_t req_addr,
	input mem_pkg::data_t req_wdata,
	input mem_pkg::strb_t req_wstrb,
	output logic req_ready,
	output logic resp_valid,
	input logic resp_ready,
	output mem_pkg::data_t resp_rdata,
	output logic resp_err,
	axi_lite_if.master bus
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_wait_resp,
		st_resp
	} state_t;

	state_t state;

	// channels still to be sent for the current request
	logic ar_pend;
	logic aw_pend;
	logic w_pend;

	// latched request
	logic is_write;
	addr_t addr_q;
	data_t wdata_q;
	strb_t wstrb_q;

	// held result
	data_t rdata_q;
	logic err_q;

	logic ar_done;
	logic aw_done;
	logic w_done;
	logic r_hs;
	logic b_hs;

	assign req_ready = (state == st_idle);

	// valids come straight from the pending flags
	assign bus.arvalid = ar_pend;
	assign bus.araddr = addr_q;
	assign bus.awvalid = aw_pend;
	assign bus.awaddr = addr_q;
	assign bus.wvalid = w_pend;
	assign bus.wdata = wdata_q;
	assign bus.wstrb = wstrb_q;

	// only the expected response channel is opened
	assign bus.rready = (state == st_wait_resp) && !is_write;
	assign bus.bready = (state == st_wait_resp) && is_write;

	// a channel is done once nothing is pending or it transfers now
	assign ar_done = !ar_pend || bus.arready;
	assign aw_done = !aw_pend || bus.awready;
	assign w_done = !w_pend || bus.wready;
	assign r_hs = bus.rvalid && bus.rready;
	assign b_hs = bus.bvalid && bus.bready;

	assign resp_valid = (state == st_resp);
	assign resp_rdata = rdata_q;
	assign resp_err = err_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ar_pend <= 1'b0;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (req_valid) begin
						state <= st_addr;
						// aw and w leave together for a store
						ar_pend <= !req_write;
						aw_pend <= req_write;
						w_pend <= req_write;
					end
				end
				st_addr: begin
					if (bus.arready)
						ar_pend <= 1'b0;
					if (bus.awready)
						aw_pend <= 1'b0;
					if (bus.wready)
						w_pend <= 1'b0;
					if (ar_done && aw_done && w_done)
						state <= st_wait_resp;
				end
				st_wait_resp: begin
					if (r_hs || b_hs)
						state <= st_resp;
				end
				st_resp: begin
					if (resp_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			is_write <= req_write;
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			wstrb_q <= req_wstrb;
		end
		if (r_hs) begin
			rdata_q <= bus.rdata;
			err_q <= (bus.rresp == `RESP_SLVERR);
		end
		// stores return zero data
		if (b_hs) begin
			rdata_q <= '0;
			err_q <= (bus.bresp == `RESP_SLVERR);
		end
	end

	// a raised request channel holds until the slice takes it
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));
	w_hold: assert property (@(posedge clk) disable iff (rst)
		bus.wvalid && !bus.wready |=> bus.wvalid && $stable(bus.wdata) && $stable(bus.wstrb));

endmodule

`default_nettype wire

// File: source/axi_reg_slice.sv
`timescale 1ns/100ps
`default_nettype none

module axi_reg_slice #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	// main entry drives the output
	logic main_valid;
	payload_t main_data;

	// skid entry catches the beat accepted during an output stall
	logic skid_valid;
	payload_t skid_data;

	// main entry is free to take a beat this cycle
	logic main_load;

	// registered ready, open while skid is empty
	assign in_ready = !skid_valid;
	assign out_valid = main_valid;
	assign out_data = main_data;
	assign main_load = out_ready || !main_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_load) begin
			// skid drains first, else take the input directly
			main_valid <= skid_valid || in_valid;
			skid_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (main_load)
			main_data <= skid_valid ? skid_data : in_data;
		if (!main_load && in_ready)
			skid_data <= in_data;
	end

	// output beat frozen under back-pressure
	out_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: sram/sram_axi_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defs.svh"

module sram_axi_slave (
	input logic clk,
	input logic rst,
	axi_lite_if.slave bus
);
	import mem_pkg::*;

	localparam int strb_w = `MEM_DATA_W / 8;
	localparam int off_w = $clog2(strb_w);
	localparam int idx_w = $clog2(`MEM_DEPTH_WORDS);
	// window size in bytes
	localparam addr_t win_bytes = addr_t'(`MEM_DEPTH_WORDS * strb_w);

	// waiting for the address handshake, or holding the response
	typedef enum logic {
		rd_ar_hs,
		rd_r_rsp
	} rd_state_t;

	typedef enum logic {
		wr_aw_hs,
		wr_b_rsp
	} wr_state_t;

	data_t mem [`MEM_DEPTH_WORDS];

	rd_state_t rd_state;
	wr_state_t wr_state;

	// offsets from the window base
	// below the base wraps to a large value and fails the range check
	addr_t rd_off;
	addr_t wr_off;
	logic rd_in_range;
	logic wr_in_range;
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;

	data_t rdata_q;
	resp_t rresp_q;
	resp_t bresp_q;

	logic ar_hs;
	logic aw_w_hs;

	assign rd_off = bus.araddr - `MEM_BASE;
	assign wr_off = bus.awaddr - `MEM_BASE;
	assign rd_in_range = (rd_off < win_bytes);
	assign wr_in_range = (wr_off < win_bytes);
	// byte lane bits dropped
	assign rd_idx = rd_off[off_w +: idx_w];
	assign wr_idx = wr_off[off_w +: idx_w];

	// read side
	assign bus.arready = (rd_state == rd_ar_hs);
	assign ar_hs = bus.arvalid && bus.arready;
	assign bus.rvalid = (rd_state == rd_r_rsp);
	assign bus.rdata = rdata_q;
	assign bus.rresp = rresp_q;

	// aw and w taken only as a pair
	assign aw_w_hs = (wr_state == wr_aw_hs) && bus.awvalid && bus.wvalid;
	assign bus.awready = aw_w_hs;
	assign bus.wready = aw_w_hs;
	assign bus.bvalid = (wr_state == wr_b_rsp);
	assign bus.bresp = bresp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_ar_hs;
		end else begin
			case (rd_state)
				rd_ar_hs: begin
					if (bus.arvalid)
						rd_state <= rd_r_rsp;
				end
				rd_r_rsp: begin
					if (bus.rready)
						rd_state <= rd_ar_hs;
				end
				default: rd_state <= rd_ar_hs;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_aw_hs;
		end else begin
			case (wr_state)
				wr_aw_hs: begin
					if (aw_w_hs)
						wr_state <= wr_b_rsp;
				end
				wr_b_rsp: begin
					if (bus.bready)
						wr_state <= wr_aw_hs;
				end
				default: wr_state <= wr_aw_hs;
			endcase
		end
	end

	// registered read, zero outside the window
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= rd_in_range ? mem[rd_idx] : '0;
			rresp_q <= rd_in_range ? `RESP_OKAY : `RESP_SLVERR;
		end
	end

	// strobed byte merge into the addressed word
	always_ff @(posedge clk) begin
		if (aw_w_hs) begin
			bresp_q <= wr_in_range ? `RESP_OKAY : `RESP_SLVERR;
			if (wr_in_range) begin
				for (int b = 0; b < strb_w; b++) begin
					if (bus.wstrb[b])
						mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	// responses wait for the master through the slices
	r_hold: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));
	b_hold: assert property (@(posedge clk) disable iff (rst)
		bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

endmodule

`default_nettype wire

// File: source/mem_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top (
	input logic clk,
	input logic rst,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input mem_pkg::addr_t req_addr,
	input mem_pkg::data_t req_wdata,
	input mem_pkg::strb_t req_wstrb,
	output logic resp_valid,
	input logic resp_ready,
	output mem_pkg::data_t resp_rdata,
	output logic resp_err
);
	import mem_pkg::*;

	// master side and slave side of the slices
	axi_lite_if m_bus ();
	axi_lite_if s_bus ();

	// w and r payloads packed for their slices
	wbeat_t w_in;
	wbeat_t w_out;
	rbeat_t r_in;
	rbeat_t r_out;

	assign w_in = '{data: m_bus.wdata, strb: m_bus.wstrb};
	assign s_bus.wdata = w_out.data;
	assign s_bus.wstrb = w_out.strb;
	assign r_in = '{data: s_bus.rdata, resp: s_bus.rresp};
	assign m_bus.rdata = r_out.data;
	assign m_bus.rresp = r_out.resp;

	lsu_axi_master master (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_rdata(resp_rdata), .resp_err(resp_err),
		.bus(m_bus)
	);

	// request channels run master to slave
	axi_reg_slice #(.payload_t(addr_t)) ar_slice (
		.clk(clk), .rst(rst),
		.in_valid(m_bus.arvalid), .in_ready(m_bus.arready), .in_data(m_bus.araddr),
		.out_valid(s_bus.arvalid), .out_ready(s_bus.arready), .out_data(s_bus.araddr)
	);

	axi_reg_slice #(.payload_t(addr_t)) aw_slice (
		.clk(clk), .rst(rst),
		.in_valid(m_bus.awvalid), .in_ready(m_bus.awready), .in_data(m_bus.awaddr),
		.out_valid(s_bus.awvalid), .out_ready(s_bus.awready), .out_data(s_bus.awaddr)
	);

	axi_reg_slice #(.payload_t(wbeat_t)) w_slice (
		.clk(clk), .rst(rst),
		.in_valid(m_bus.wvalid), .in_ready(m_bus.wready), .in_data(w_in),
		.out_valid(s_bus.wvalid), .out_ready(s_bus.wready), .out_data(w_out)
	);

	// response channels run slave to master
	axi_reg_slice #(.payload_t(rbeat_t)) r_slice (
		.clk(clk), .rst(rst),
		.in_valid(s_bus.rvalid), .in_ready(s_bus.rready), .in_data(r_in),
		.out_valid(m_bus.rvalid), .out_ready(m_bus.rready), .out_data(r_out)
	);

	axi_reg_slice #(.payload_t(resp_t)) b_slice (
		.clk(clk), .rst(rst),
		.in_valid(s_bus.bvalid), .in_ready(s_bus.bready), .in_data(s_bus.bresp),
		.out_valid(m_bus.bvalid), .out_ready(m_bus.bready), .out_data(m_bus.bresp)
	);

	sram_axi_slave sram (
		.clk(clk),
		.rst(rst),
		.bus(s_bus)
	);

endmodule

`default_nettype wire

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem_tb;
	import mem_pkg::*;

	localparam int clk_half = 20;
	localparam int drive_dly = 2;
	localparam int reset_cycles = 16;
	localparam int timeout_cycles = 200;
	localparam int seed = 92327;
	localparam int rand_ops = 60;
	// random mix stays on a small set of words so reads hit written data
	localparam int rand_words = 64;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	logic req_write;
	addr_t req_addr;
	data_t req_wdata;
	strb_t req_wstrb;
	logic resp_valid;
	logic resp_ready;
	data_t resp_rdata;
	logic resp_err;

	// shadow model of the sram contents
	data_t shadow [`MEM_DEPTH_WORDS];
	logic written [`MEM_DEPTH_WORDS];
	int op_count;
	int rng_seed;

	mem_subsystem_top uut (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_rdata(resp_rdata), .resp_err(resp_err)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	// window check straight from the memory map
	function automatic logic in_window(addr_t addr);
		return (addr >= `MEM_BASE) && (addr < `MEM_BASE + `MEM_DEPTH_WORDS * 8);
	endfunction

	// low three bits ignored
	function automatic int word_index(addr_t addr);
		return ((addr - `MEM_BASE) >> 3) % `MEM_DEPTH_WORDS;
	endfunction

	function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
		data_t result;
		result = old_word;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	task automatic stop_on_failure();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	// holds the request until req_ready is seen and drops it after the transfer
	task automatic send_request(input string name, input logic write, input addr_t addr,
			input data_t data, input strb_t strb);
		int cycles;
		cycles = 0;
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = data;
		req_wstrb = strb;
		while (!req_ready) begin
			@(posedge clk);
			#drive_dly;
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("Timeout: req_ready never rose during %s", name);
				stop_on_failure();
			end
		end
		@(posedge clk);
		#drive_dly;
		req_valid = 1'b0;
	endtask

	// waits for resp_valid and stalls resp_ready before taking it
	task automatic take_response(input string name, input int stall,
			output data_t rdata, output logic err);
		int cycles;
		data_t held_data;
		logic held_err;
		cycles = 0;
		while (!resp_valid) begin
			@(posedge clk);
			#drive_dly;
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("Timeout: resp_valid never rose during %s", name);
				stop_on_failure();
			end
		end
		held_data = resp_rdata;
		held_err = resp_err;
		// response must stay frozen while the requester stalls
		for (int i = 0; i < stall; i++) begin
			@(posedge clk);
			#drive_dly;
			check_value({name, " stall valid"}, 64'd1, resp_valid);
			check_value({name, " stall data"}, held_data, resp_rdata);
			check_value({name, " stall err"}, held_err, resp_err);
		end
		rdata = resp_rdata;
		err = resp_err;
		resp_ready = 1'b1;
		@(posedge clk);
		#drive_dly;
		resp_ready = 1'b0;
		op_count++;
	endtask

	task automatic do_write(input string name, input addr_t addr, input data_t data,
			input strb_t strb, input int stall);
		data_t rdata;
		logic err;
		logic exp_err;
		int idx;
		exp_err = !in_window(addr);
		send_request(name, 1'b1, addr, data, strb);
		take_response(name, stall, rdata, err);
		check_value({name, " err"}, exp_err, err);
		// stores always return zero data
		check_value({name, " data"}, '0, rdata);
		if (!exp_err) begin
			idx = word_index(addr);
			shadow[idx] = merge_bytes(shadow[idx], data, strb);
			written[idx] = 1'b1;
		end
	endtask

	task automatic do_read(input string name, input addr_t addr, input int stall);
		data_t rdata;
		logic err;
		logic exp_err;
		data_t exp_data;
		exp_err = !in_window(addr);
		exp_data = exp_err ? '0 : shadow[word_index(addr)];
		send_request(name, 1'b0, addr, '0, '0);
		take_response(name, stall, rdata, err);
		check_value({name, " err"}, exp_err, err);
		check_value({name, " data"}, exp_data, rdata);
	endtask

	initial begin
		addr_t addrs [5];
		addr_t addr;
		addr_t near_addr;
		data_t data;
		strb_t strb;
		logic write;
		int idx;
		rng_seed = seed;
		void'($urandom(rng_seed));
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_wstrb = '0;
		resp_ready = 1'b0;
		op_count = 0;
		for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
			shadow[i] = '0;
			written[i] = 1'b0;
		end
		repeat (reset_cycles) @(posedge clk);
		#drive_dly;
		rst = 1'b0;

		// reset state
		check_value("reset req_ready", 64'd1, req_ready);
		check_value("reset resp_valid", 64'd0, resp_valid);

		// full words on first and last word and one address with low bits set
		addrs[0] = `MEM_BASE;
		addrs[1] = `MEM_BASE + 32'h8;
		addrs[2] = `MEM_BASE + 32'h100;
		addrs[3] = `MEM_BASE + (`MEM_DEPTH_WORDS - 1) * 8;
		addrs[4] = `MEM_BASE + 32'h2c;
		foreach (addrs[i]) begin
			data = {addrs[i], ~addrs[i]} ^ 64'h5a5a_0000_0000_a5a5;
			do_write($sformatf("full write %0d", i), addrs[i], data, 8'hff, 0);
		end
		// read back only once every word holds its own value
		foreach (addrs[i]) begin
			do_read($sformatf("full read %0d", i), addrs[i], 0);
		end

		// sparse strobes merged into an old word
		addr = `MEM_BASE + 32'h40;
		do_write("strobe base", addr, 64'h0123_4567_89ab_cdef, 8'hff, 0);
		do_write("strobe a5", addr, 64'hffee_ddcc_bbaa_9988, 8'b1010_0101, 0);
		do_read("strobe read a5", addr, 0);
		do_write("strobe 10", addr, 64'h1111_2222_3333_4444, 8'h10, 0);
		do_read("strobe read 10", addr, 0);

		// out of window below the base and past the last word
		near_addr = `MEM_BASE + 32'h18;
		do_write("range guard word", near_addr, 64'hcafe_f00d_dead_beef, 8'hff, 0);
		do_write("range write low", 32'h7fff_f018, 64'h1, 8'hff, 0);
		do_write("range write high", `MEM_BASE + `MEM_DEPTH_WORDS * 8 + 32'h18,
			64'h2, 8'hff, 0);
		do_read("range read low", 32'h7fff_f018, 0);
		do_read("range read high", `MEM_BASE + `MEM_DEPTH_WORDS * 8 + 32'h18, 0);
		do_read("range guard read", near_addr, 0);

		// requester back-pressure on both response kinds
		addr = `MEM_BASE + 32'h80;
		data = {$urandom, $urandom};
		do_write("stall write", addr, data, 8'hff, $urandom_range(20, 5));
		do_read("stall read", addr, $urandom_range(20, 5));

		// random mix where unwritten words get a full store first
		for (int n = 0; n < rand_ops; n++) begin
			idx = $urandom_range(rand_words - 1, 0);
			addr = `MEM_BASE + idx * 8 + $urandom_range(7, 0);
			write = $urandom_range(1, 0);
			strb = $urandom_range(255, 0);
			if (!written[idx]) begin
				write = 1'b1;
				strb = 8'hff;
			end
			if (write) begin
				data = {$urandom, $urandom};
				do_write($sformatf("random write %0d", n), addr, data, strb,
					$urandom_range(3, 0));
			end else begin
				do_read($sformatf("random read %0d", n), addr, $urandom_range(3, 0));
			end
		end

		$display("%0d transactions checked", op_count);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_subsystem.f
+incdir+common
common/mem_pkg.sv
common/axi_lite_if.sv
source/lsu_axi_master.sv
source/axi_reg_slice.sv
sram/sram_axi_slave.sv
source/mem_subsystem_top.sv
bench/mem_subsystem_tb.sv
